//--- source/csr_pkg.sv
package csr_pkg;

    // Zicsr operations, encoded as funct3
    typedef enum logic [2:0] {
        op_rw  = 3'b001,
        op_rs  = 3'b010,
        op_rc  = 3'b011,
        op_rwi = 3'b101,
        op_rsi = 3'b110,
        op_rci = 3'b111
    } csr_op_t;

    localparam logic [11:0] addr_mcycle    = 12'hB00;
    localparam logic [11:0] addr_minstret  = 12'hB02;
    localparam logic [11:0] addr_mcycleh   = 12'hB80;
    localparam logic [11:0] addr_minstreth = 12'hB82;
    localparam logic [11:0] addr_mvendorid = 12'hF11;
    localparam logic [11:0] addr_marchid   = 12'hF12;
    localparam logic [11:0] addr_mimpid    = 12'hF13;
    localparam logic [11:0] addr_mhartid   = 12'hF14;
    localparam logic [11:0] addr_mstatus   = 12'h300;
    localparam logic [11:0] addr_misa      = 12'h301;
    localparam logic [11:0] addr_mtvec     = 12'h305;
    localparam logic [11:0] addr_mepc      = 12'h341;
    localparam logic [11:0] addr_mcause    = 12'h342;

    localparam logic [31:0] mvendorid_value = 32'h5256_4B43;
    localparam logic [31:0] marchid_value   = 32'h3436_5335;
    localparam logic [31:0] mimpid_value    = 32'h3436_4931;
    localparam logic [31:0] mhartid_value   = 32'h524B_4330;
    localparam logic [31:0] mstatus_value   = 32'h0000_1800;  // mpp = machine
    localparam logic [31:0] misa_value      = 32'h4000_0100;  // mxl 32, base I

    localparam logic [31:0] mtvec_reset_value = 32'h0000_1000;

endpackage

//--- source/csr_file.sv
module csr_file #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            csr_request,
    input  logic [11:0]     csr_address,
    input  logic            write_enable,
    input  logic [11:0]     write_address,
    input  logic [XLEN-1:0] write_data,
    input  logic            instruction_retired,
    output logic [XLEN-1:0] csr_read_out,
    output logic            csr_ready,
    output logic            illegal_address,
    output logic [XLEN-1:0] mtvec
);
    import csr_pkg::*;

    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [63:0]     mcycle;
    logic [63:0]     minstret;

    logic            processing;     // second cycle of an access
    logic            start_access;
    logic            valid_address;
    logic [XLEN-1:0] read_data;

    assign start_access    = csr_request && !processing;
    assign csr_ready       = !start_access;               // stall during first cycle
    assign illegal_address = processing && !valid_address;

    // address decode and read mux
    always_comb begin
        valid_address = 1'b1;
        case (csr_address)
            addr_mcycle:    read_data = XLEN'(mcycle[31:0]);
            addr_minstret:  read_data = XLEN'(minstret[31:0]);
            addr_mcycleh:   read_data = XLEN'(mcycle[63:32]);
            addr_minstreth: read_data = XLEN'(minstret[63:32]);
            addr_mvendorid: read_data = XLEN'(mvendorid_value);
            addr_marchid:   read_data = XLEN'(marchid_value);
            addr_mimpid:    read_data = XLEN'(mimpid_value);
            addr_mhartid:   read_data = XLEN'(mhartid_value);
            addr_mstatus:   read_data = XLEN'(mstatus_value);
            addr_misa:      read_data = XLEN'(misa_value);
            addr_mtvec:     read_data = mtvec;
            addr_mepc:      read_data = mepc;
            addr_mcause:    read_data = mcause;
            default: begin
                read_data     = '0;
                valid_address = 1'b0;
            end
        endcase
    end

    // access sequencing and counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mcycle       <= '0;
            minstret     <= '0;
            processing   <= 1'b0;
            csr_read_out <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (instruction_retired) begin
                minstret <= minstret + 64'd1;
            end

            if (start_access) begin
                processing   <= 1'b1;
                csr_read_out <= read_data;      // old value, before any write
            end else if (processing) begin
                processing <= 1'b0;
            end
        end
    end

    // single write port, read-only targets fall through
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtvec  <= XLEN'(mtvec_reset_value);
            mepc   <= '0;
            mcause <= '0;
        end else if (write_enable) begin
            case (write_address)
                addr_mtvec:  mtvec  <= {write_data[XLEN-1:2], 2'b00};  // word aligned base
                addr_mepc:   mepc   <= {write_data[XLEN-1:2], 2'b00};
                addr_mcause: mcause <= write_data;
                default: ;
            endcase
        end
    end

endmodule

//--- source/csr_op_unit.sv
module csr_op_unit #(
    parameter int XLEN = 32
) (
    input  logic             csr_request,
    input  logic             csr_ready,
    input  csr_pkg::csr_op_t csr_op,
    input  logic [XLEN-1:0]  rs1_value,
    input  logic [4:0]       uimm,
    input  logic [XLEN-1:0]  csr_read_out,
    output logic             op_write_enable,
    output logic [XLEN-1:0]  op_write_data
);
    import csr_pkg::*;

    logic [XLEN-1:0] source;
    logic            immediate_form;
    logic            source_nonzero;
    logic            write_wanted;

    assign immediate_form = (csr_op == op_rwi) || (csr_op == op_rsi) || (csr_op == op_rci);
    assign source         = immediate_form ? XLEN'(uimm) : rs1_value;  // zero-extended uimm
    assign source_nonzero = |source;

    always_comb begin
        case (csr_op)
            op_rw, op_rwi: begin
                op_write_data = source;
                write_wanted  = 1'b1;
            end
            op_rs, op_rsi: begin
                op_write_data = csr_read_out | source;
                write_wanted  = source_nonzero;    // set with zero is a plain read
            end
            op_rc, op_rci: begin
                op_write_data = csr_read_out & ~source;
                write_wanted  = source_nonzero;
            end
            default: begin
                op_write_data = csr_read_out;
                write_wanted  = 1'b0;
            end
        endcase
    end

    // request with ready high only happens in the second access cycle
    assign op_write_enable = csr_request && csr_ready && write_wanted;

endmodule

//--- source/trap_sequencer.sv
module trap_sequencer #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            trap_request,
    input  logic [XLEN-1:0] trap_pc,
    input  logic [XLEN-1:0] trap_cause,
    input  logic            op_write_enable,
    input  logic [XLEN-1:0] op_write_data,
    input  logic [11:0]     csr_address,
    input  logic [XLEN-1:0] mtvec,
    output logic            write_enable,
    output logic [11:0]     write_address,
    output logic [XLEN-1:0] write_data,
    output logic            trap_busy,
    output logic [XLEN-1:0] trap_vector
);
    import csr_pkg::*;

    typedef enum logic [1:0] {
        idle,
        write_epc,
        write_cause
    } trap_state_t;

    trap_state_t     state;
    trap_state_t     next_state;
    logic [XLEN-1:0] epc_latch;
    logic [XLEN-1:0] cause_latch;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // trap payload, captured only when a trap is accepted
    always_ff @(posedge clk) begin
        if (state == idle && trap_request) begin
            epc_latch   <= {trap_pc[XLEN-1:2], 2'b00};
            cause_latch <= trap_cause;
        end
    end

    always_comb begin
        case (state)
            idle:        next_state = trap_request ? write_epc : idle;
            write_epc:   next_state = write_cause;
            write_cause: next_state = idle;
            default:     next_state = idle;
        endcase
    end

    // write port arbitration, trap owns it while busy
    always_comb begin
        case (state)
            write_epc: begin
                write_enable  = 1'b1;
                write_address = addr_mepc;
                write_data    = epc_latch;
            end
            write_cause: begin
                write_enable  = 1'b1;
                write_address = addr_mcause;
                write_data    = cause_latch;
            end
            default: begin
                write_enable  = op_write_enable;  // op write forwarded when idle
                write_address = csr_address;
                write_data    = op_write_data;
            end
        endcase
    end

    assign trap_busy   = (state != idle);
    assign trap_vector = mtvec;

endmodule

//--- source/csr_unit.sv
module csr_unit #(
    parameter int XLEN = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             csr_request,
    input  csr_pkg::csr_op_t csr_op,
    input  logic [11:0]      csr_address,
    input  logic [XLEN-1:0]  rs1_value,
    input  logic [4:0]       uimm,
    input  logic             instruction_retired,
    input  logic             trap_request,
    input  logic [XLEN-1:0]  trap_pc,
    input  logic [XLEN-1:0]  trap_cause,
    output logic [XLEN-1:0]  csr_read_out,
    output logic             csr_ready,
    output logic             illegal_address,
    output logic [XLEN-1:0]  trap_vector,
    output logic             trap_busy
);

    logic            op_write_enable;
    logic [XLEN-1:0] op_write_data;
    logic            write_enable;
    logic [11:0]     write_address;
    logic [XLEN-1:0] write_data;
    logic [XLEN-1:0] mtvec;

    csr_file #(.XLEN(XLEN)) csr_file0 (
        .clk                 (clk),
        .reset               (reset),
        .csr_request         (csr_request),
        .csr_address         (csr_address),
        .write_enable        (write_enable),
        .write_address       (write_address),
        .write_data          (write_data),
        .instruction_retired (instruction_retired),
        .csr_read_out        (csr_read_out),
        .csr_ready           (csr_ready),
        .illegal_address     (illegal_address),
        .mtvec               (mtvec)
    );

    csr_op_unit #(.XLEN(XLEN)) csr_op_unit0 (
        .csr_request     (csr_request),
        .csr_ready       (csr_ready),
        .csr_op          (csr_op),
        .rs1_value       (rs1_value),
        .uimm            (uimm),
        .csr_read_out    (csr_read_out),
        .op_write_enable (op_write_enable),
        .op_write_data   (op_write_data)
    );

    trap_sequencer #(.XLEN(XLEN)) trap_sequencer0 (
        .clk             (clk),
        .reset           (reset),
        .trap_request    (trap_request),
        .trap_pc         (trap_pc),
        .trap_cause      (trap_cause),
        .op_write_enable (op_write_enable),
        .op_write_data   (op_write_data),
        .csr_address     (csr_address),
        .mtvec           (mtvec),
        .write_enable    (write_enable),
        .write_address   (write_address),
        .write_data      (write_data),
        .trap_busy       (trap_busy),
        .trap_vector     (trap_vector)
    );

endmodule

//--- testbench/csr_unit_properties.sv
module csr_unit_properties (
    input logic clk,
    input logic reset,
    input logic csr_request,
    input logic csr_ready,
    input logic trap_request,
    input logic trap_busy,
    input logic write_enable
);
    timeunit 1ns;
    timeprecision 100ps;

    // stall in the first cycle only
    assert property (@(posedge clk) disable iff (reset)
        $rose(csr_request) |-> !csr_ready ##1 csr_ready)
        else $error("csr_ready did not follow the two-cycle access pattern");

    assert property (@(posedge clk) disable iff (reset) trap_busy |-> !csr_request)
        else $error("csr_request raised while trap_busy is high");

    assert property (@(posedge clk) disable iff (reset) trap_request |-> !csr_request)
        else $error("trap_request pulsed during a CSR access");

    assert property (@(posedge clk) disable iff (reset)
        $rose(trap_busy) |=> trap_busy ##1 !trap_busy)
        else $error("trap_busy did not last exactly two cycles");

    assert property (@(posedge clk) reset |-> !write_enable)
        else $error("write_enable high during reset");

endmodule

bind csr_unit csr_unit_properties props0 (
    .clk          (clk),
    .reset        (reset),
    .csr_request  (csr_request),
    .csr_ready    (csr_ready),
    .trap_request (trap_request),
    .trap_busy    (trap_busy),
    .write_enable (write_enable)
);

//--- testbench/csr_unit_tb.sv
module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int XLEN = 32;
    localparam int wait_limit = 8;

    logic clk, reset, csr_request, instruction_retired, trap_request;
    csr_op_t csr_op;
    logic [11:0] csr_address;
    logic [31:0] rs1_value, trap_pc, trap_cause, csr_read_out, trap_vector;
    logic [4:0] uimm;
    logic csr_ready, illegal_address, trap_busy;

    logic [31:0] model_mtvec, model_mepc, model_mcause, last_mcycle;
    logic [63:0] model_retired;

    csr_op_t op_list[6] = '{op_rw, op_rs, op_rc, op_rwi, op_rsi, op_rci};
    logic [11:0] address_list[16] = '{addr_mtvec, addr_mepc, addr_mcause, addr_mtvec,
        addr_mepc, addr_mcause, addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid,
        addr_mstatus, addr_misa, addr_minstret, addr_minstreth, 12'h7C3, 12'h000};

    csr_unit #(.XLEN(XLEN)) dut0 (.clk(clk), .reset(reset), .csr_request(csr_request),
        .csr_op(csr_op), .csr_address(csr_address), .rs1_value(rs1_value), .uimm(uimm),
        .instruction_retired(instruction_retired), .trap_request(trap_request),
        .trap_pc(trap_pc), .trap_cause(trap_cause), .csr_read_out(csr_read_out),
        .csr_ready(csr_ready), .illegal_address(illegal_address),
        .trap_vector(trap_vector), .trap_busy(trap_busy));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] address);
        case (address)
            addr_minstret:  return model_retired[31:0];
            addr_minstreth: return model_retired[63:32];
            addr_mvendorid: return mvendorid_value;
            addr_marchid:   return marchid_value;
            addr_mimpid:    return mimpid_value;
            addr_mhartid:   return mhartid_value;
            addr_mstatus:   return mstatus_value;
            addr_misa:      return misa_value;
            addr_mtvec:     return model_mtvec;
            addr_mepc:      return model_mepc;
            addr_mcause:    return model_mcause;
            default:        return 32'h0;  // unknown reads as zero
        endcase
    endfunction

    function automatic logic model_known(input logic [11:0] address);
        return (address == addr_mcycle) || (address == addr_mcycleh) ||
               (address == addr_minstret) || (address == addr_minstreth) ||
               (address[11:8] == 4'hF && address[7:0] >= 8'h11 && address[7:0] <= 8'h14) ||
               (address == addr_mstatus) || (address == addr_misa) ||
               (address == addr_mtvec) || (address == addr_mepc) || (address == addr_mcause);
    endfunction

    // one full access with the old value from the ready cycle
    task automatic csr_access(input csr_op_t op, input logic [11:0] address,
                              input logic [31:0] rs1, input logic [4:0] imm,
                              output logic [31:0] read_value);
        int waited;
        next_cycle();
        csr_request = 1'b1;
        csr_op      = op;
        csr_address = address;
        rs1_value   = rs1;
        uimm        = imm;
        #1;
        check_value("csr_ready", csr_ready, 1'b0);  // stalled in first cycle
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (waited > wait_limit) stop_run("timed out waiting for csr_ready to rise");
        end while (!csr_ready);
        check_value("access_latency", waited, 1);
        check_value("illegal_address", illegal_address, !model_known(address));
        read_value = csr_read_out;
        next_cycle();  // write commits on this edge
        csr_request = 1'b0;
    endtask

    task automatic read_check(input logic [11:0] address);
        logic [31:0] value;
        csr_access(op_rs, address, 32'h0, 5'h0, value);
        check_value($sformatf("csr_read_out[%h]", address), value, model_read(address));
    endtask

    task automatic random_op();
        csr_op_t     op;
        logic [11:0] address;
        logic [31:0] rs1, source, old_value, new_value, read_value;
        logic [4:0]  imm;
        logic        write;
        op        = op_list[$urandom_range(0, 5)];
        address   = address_list[$urandom_range(0, 15)];
        rs1       = ($urandom_range(0, 3) == 0) ? 32'h0 : $urandom();
        imm       = 5'($urandom_range(0, 31));
        old_value = model_read(address);
        source    = (op == op_rwi || op == op_rsi || op == op_rci) ? {27'h0, imm} : rs1;
        case (op)
            op_rw, op_rwi: begin
                new_value = source;
                write     = 1'b1;
            end
            op_rs, op_rsi: begin
                new_value = old_value | source;
                write     = |source;
            end
            default: begin
                new_value = old_value & ~source;
                write     = |source;
            end
        endcase
        csr_access(op, address, rs1, imm, read_value);
        check_value($sformatf("csr_read_out[%h]", address), read_value, old_value);
        if (write && address == addr_mtvec) model_mtvec = {new_value[31:2], 2'b00};
        if (write && address == addr_mepc) model_mepc = {new_value[31:2], 2'b00};
        if (write && address == addr_mcause) model_mcause = new_value;
        check_value("trap_vector", trap_vector, model_mtvec);
    endtask

    task automatic raise_trap(input logic [31:0] pc, input logic [31:0] cause);
        int busy_cycles;
        next_cycle();
        trap_request = 1'b1;
        trap_pc      = pc;
        trap_cause   = cause;
        next_cycle();
        trap_request = 1'b0;
        busy_cycles  = 0;
        while (trap_busy) begin
            busy_cycles++;
            if (busy_cycles > wait_limit) stop_run("timed out waiting for trap_busy to drop");
            next_cycle();
        end
        check_value("trap_busy_cycles", busy_cycles, 2);
        model_mepc   = {pc[31:2], 2'b00};
        model_mcause = cause;
        read_check(addr_mepc);
        read_check(addr_mcause);
    endtask

    task automatic retire_pulse();
        next_cycle();
        instruction_retired = 1'b1;
        next_cycle();
        instruction_retired = 1'b0;
        model_retired = model_retired + 64'd1;
    endtask

    task automatic check_mcycle();
        logic [31:0] low, high;
        csr_access(op_rs, addr_mcycle, 32'h0, 5'h0, low);
        csr_access(op_rs, addr_mcycleh, 32'h0, 5'h0, high);
        check_value("mcycle_increasing", low > last_mcycle, 1'b1);
        check_value("mcycleh", high, 32'h0);  // low half far from wrapping
        last_mcycle = low;
    endtask

    initial begin
        int seed_value;
        int choice;
        seed_value = $urandom(98943);
        reset = 1'b1;
        csr_request = 1'b0;
        csr_op = op_rw;
        csr_address = 12'h0;
        rs1_value = 32'h0;
        uimm = 5'h0;
        instruction_retired = 1'b0;
        trap_request = 1'b0;
        trap_pc = 32'h0;
        trap_cause = 32'h0;
        model_mtvec = mtvec_reset_value;
        model_mepc = 32'h0;
        model_mcause = 32'h0;
        model_retired = 64'h0;
        last_mcycle = 32'h0;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;

        check_value("csr_ready", csr_ready, 1'b1);
        check_value("csr_read_out", csr_read_out, 32'h0);
        check_value("illegal_address", illegal_address, 1'b0);
        check_value("trap_busy", trap_busy, 1'b0);
        check_value("trap_vector", trap_vector, mtvec_reset_value);
        for (int i = 0; i < 16; i++) read_check(address_list[i]);

        for (int i = 0; i < 300; i++) begin
            choice = $urandom_range(0, 9);
            if (choice == 0) raise_trap($urandom(), $urandom());
            else if (choice == 1) retire_pulse();
            else if (choice == 2) check_mcycle();
            random_op();
        end
        read_check(addr_minstret);
        read_check(addr_minstreth);
        check_mcycle();

        $display("Test passed");
        $finish;
    end

endmodule

//--- sources.f
source/csr_pkg.sv
source/csr_file.sv
source/csr_op_unit.sv
source/trap_sequencer.sv
source/csr_unit.sv
testbench/csr_unit_properties.sv
testbench/csr_unit_tb.sv
